/* hw/mulbt_cfg.svh */
`ifndef MULBT_CFG_SVH
`define MULBT_CFG_SVH

// operand and result word width
`define MULBT_XLEN 32

// radix-4 groups over the 33-bit extended multiplier
`define MULBT_NUM_PP 17

// partial product and full product width
`define MULBT_PP_W 66

// tag carried alongside each operation
`define MULBT_TAG_W 4

`endif

/* hw/mulbt_pkg.sv */
`default_nettype none

package mulbt_pkg;

`include "mulbt_cfg.svh"

    // M-extension multiply flavours
    typedef enum logic [1:0] {
        opMul    = 2'd0,    // low word
        opMulh   = 2'd1,    // high word, signed x signed
        opMulhsu = 2'd2,    // high word, signed x unsigned
        opMulhu  = 2'd3     // high word, unsigned x unsigned
    } mulOp_t;

    // one row per Booth group, already shifted into place
    typedef logic [`MULBT_NUM_PP-1:0][`MULBT_PP_W-1:0] ppArray_t;

endpackage

`default_nettype wire

/* hw/mulbt_if.sv */
`default_nettype none
`timescale 1ns/10ps

`include "mulbt_cfg.svh"

// stage 1 to stage 2, the partial product rows
interface ppBus_if;
    import mulbt_pkg::*;

    logic                    valid;
    mulOp_t                  op;
    logic [`MULBT_TAG_W-1:0] tag;
    ppArray_t                pp;

    modport src (output valid, op, tag, pp);
    modport snk (input  valid, op, tag, pp);
endinterface

// stage 2 to stage 3, redundant sum/carry form of the product
interface scBus_if;
    import mulbt_pkg::*;

    logic                    valid;
    mulOp_t                  op;
    logic [`MULBT_TAG_W-1:0] tag;
    logic [`MULBT_PP_W-1:0]  sum;
    logic [`MULBT_PP_W-1:0]  carry;

    modport src (output valid, op, tag, sum, carry);
    modport snk (input  valid, op, tag, sum, carry);
endinterface

`default_nettype wire

/* hw/boothEncoder.sv */
`default_nettype none
`timescale 1ns/10ps

`include "mulbt_cfg.svh"

module boothEncoder (
    input  wire  [2:0]               grp,           // b[2i+1], b[2i], b[2i-1]
    input  wire  [`MULBT_PP_W-1:0]   multiplicand,  // already extended
    output logic [`MULBT_PP_W-1:0]   pp
);

    logic                   neg;    // digit is negative
    logic                   one;    // |digit| == 1
    logic                   two;    // |digit| == 2
    logic [`MULBT_PP_W-1:0] mag;

    // radix-4 recoding table
    always_comb begin
        neg = 1'b0;
        one = 1'b0;
        two = 1'b0;
        case (grp)
            3'b001, 3'b010: one = 1'b1;     // +1
            3'b011:         two = 1'b1;     // +2
            3'b100: begin                   // -2
                two = 1'b1;
                neg = 1'b1;
            end
            3'b101, 3'b110: begin           // -1
                one = 1'b1;
                neg = 1'b1;
            end
            default: ;                      // 000 / 111 give zero
        endcase
    end

    assign mag = two ? {multiplicand[`MULBT_PP_W-2:0], 1'b0} :
                 one ? multiplicand : '0;

    // two's complement negate, wraps mod 2^66
    assign pp = neg ? (~mag + 1'b1) : mag;

endmodule

`default_nettype wire

/* hw/ppGenerator.sv */
`default_nettype none
`timescale 1ns/10ps

`include "mulbt_cfg.svh"

module ppGenerator (
    input  wire                           clk,
    input  wire                           arstN,
    input  wire                           inValid,
    input  wire  [`MULBT_TAG_W-1:0]       inTag,
    input  wire  mulbt_pkg::mulOp_t       op,
    input  wire  [`MULBT_XLEN-1:0]        op1,    // multiplicand, rs1
    input  wire  [`MULBT_XLEN-1:0]        op2,    // multiplier, rs2
    ppBus_if.src                          ppOut
);

    import mulbt_pkg::*;

    logic                     aSigned;
    logic                     bSigned;
    logic [`MULBT_XLEN:0]     aExt;       // 33 bits
    logic [`MULBT_XLEN:0]     bExt;
    logic [`MULBT_PP_W-1:0]   mcand;
    logic [`MULBT_XLEN+2:0]   mpPad;      // sign copy on top, zero below bit 0
    ppArray_t                 ppComb;

    wire  [`MULBT_PP_W-1:0]   encOut [`MULBT_NUM_PP];

    // low word is the same either way
    assign aSigned = (op != opMulhu);
    assign bSigned = (op == opMul) || (op == opMulh);

    assign aExt  = {aSigned & op1[`MULBT_XLEN-1], op1};
    assign bExt  = {bSigned & op2[`MULBT_XLEN-1], op2};
    assign mcand = {{(`MULBT_PP_W-`MULBT_XLEN-1){aExt[`MULBT_XLEN]}}, aExt};
    assign mpPad = {bExt[`MULBT_XLEN], bExt, 1'b0};

    for (genvar i = 0; i < `MULBT_NUM_PP; i++) begin : gEnc
        boothEncoder uEnc (
            .grp          (mpPad[2*i+2 -: 3]),
            .multiplicand (mcand),
            .pp           (encOut[i])
        );
    end

    // weight of group i is 4^i
    always_comb begin
        for (int k = 0; k < `MULBT_NUM_PP; k++) begin
            ppComb[k] = encOut[k] << (2 * k);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ppOut.valid <= 1'b0;
        end else begin
            ppOut.valid <= inValid;
        end
    end

    // payload only moves with a live item
    always_ff @(posedge clk) begin
        if (inValid) begin
            ppOut.op  <= op;
            ppOut.tag <= inTag;
            ppOut.pp  <= ppComb;
        end
    end

endmodule

`default_nettype wire

/* hw/csaTree.sv */
`default_nettype none
`timescale 1ns/10ps

`include "mulbt_cfg.svh"

module csaTree (
    input  wire      clk,
    input  wire      arstN,
    ppBus_if.snk     ppIn,
    scBus_if.src     scOut
);

    import mulbt_pkg::*;

    localparam int W = `MULBT_PP_W;
    localparam int NUM = `MULBT_NUM_PP;

    // each 3:2 layer turns every three rows into two, leftovers pass
    function automatic int rowsAfter(input int n);
        return (n / 3) * 2 + n % 3;
    endfunction

    function automatic int rowsAt(input int layer);
        int n;
        n = NUM;
        for (int k = 0; k < layer; k++) begin
            n = rowsAfter(n);
        end
        return n;
    endfunction

    function automatic int layerCount(input int n);
        int cnt;
        int rows;
        cnt  = 0;
        rows = n;
        while (rows > 2) begin
            rows = rowsAfter(rows);
            cnt++;
        end
        return cnt;
    endfunction

    // full adder per bit, carry moved up one weight
    function automatic logic [2*W-1:0] csa32(
        input logic [W-1:0] a,
        input logic [W-1:0] b,
        input logic [W-1:0] c
    );
        logic [W-1:0] s;
        logic [W-1:0] cy;
        s  = a ^ b ^ c;
        cy = ((a & b) | (a & c) | (b & c)) << 1;
        return {s, cy};
    endfunction

    localparam int LAYERS = layerCount(NUM);   // 17-12-8-6-4-3-2

    wire [W-1:0] lay [0:LAYERS][0:NUM-1];

    for (genvar r = 0; r < NUM; r++) begin : gIn
        assign lay[0][r] = ppIn.pp[r];
    end

    for (genvar l = 0; l < LAYERS; l++) begin : gLayer
        localparam int N = rowsAt(l);
        localparam int G = N / 3;
        for (genvar g = 0; g < G; g++) begin : gCsa
            assign {lay[l+1][2*g], lay[l+1][2*g+1]} =
                csa32(lay[l][3*g], lay[l][3*g+1], lay[l][3*g+2]);
        end
        for (genvar r = 0; r < N % 3; r++) begin : gPass
            assign lay[l+1][2*G+r] = lay[l][3*G+r];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            scOut.valid <= 1'b0;
        end else begin
            scOut.valid <= ppIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ppIn.valid) begin
            scOut.op    <= ppIn.op;
            scOut.tag   <= ppIn.tag;
            scOut.sum   <= lay[LAYERS][0];
            scOut.carry <= lay[LAYERS][1];
        end
    end

endmodule

`default_nettype wire

/* hw/finalAdder.sv */
`default_nettype none
`timescale 1ns/10ps

`include "mulbt_cfg.svh"

module finalAdder (
    input  wire                        clk,
    input  wire                        arstN,
    scBus_if.snk                       scIn,
    output logic                       outValid,
    output logic [`MULBT_TAG_W-1:0]    outTag,
    output logic [`MULBT_XLEN-1:0]     res
);

    import mulbt_pkg::*;

    logic [`MULBT_PP_W-1:0] prod;
    logic [`MULBT_XLEN-1:0] word;

    // carry-propagate, top two bits fall away
    assign prod = scIn.sum + scIn.carry;

    always_comb begin
        case (scIn.op)
            opMul:   word = prod[`MULBT_XLEN-1:0];
            default: word = prod[2*`MULBT_XLEN-1:`MULBT_XLEN];  // all high variants
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= scIn.valid;
        end
    end

    // held until the next live result
    always_ff @(posedge clk) begin
        if (scIn.valid) begin
            outTag <= scIn.tag;
            res    <= word;
        end
    end

endmodule

`default_nettype wire

/* hw/mulbtTop.sv */
`default_nettype none
`timescale 1ns/10ps

`include "mulbt_cfg.svh"

module mulbtTop (
    input  wire                        clk,
    input  wire                        arstN,
    input  wire                        inValid,
    input  wire  [`MULBT_TAG_W-1:0]    inTag,
    input  wire  mulbt_pkg::mulOp_t    op,
    input  wire  [`MULBT_XLEN-1:0]     op1,
    input  wire  [`MULBT_XLEN-1:0]     op2,
    output logic                       outValid,
    output logic [`MULBT_TAG_W-1:0]    outTag,
    output logic [`MULBT_XLEN-1:0]     res
);

    ppBus_if ppBus ();     // stage 1 -> 2
    scBus_if scBus ();     // stage 2 -> 3

    // Booth recoding and partial products, registered at edge 1
    ppGenerator uPpGen (
        .clk     (clk),
        .arstN   (arstN),
        .inValid (inValid),
        .inTag   (inTag),
        .op      (op),
        .op1     (op1),
        .op2     (op2),
        .ppOut   (ppBus.src)
    );

    // carry-save reduction, edge 2
    csaTree uCsa (
        .clk   (clk),
        .arstN (arstN),
        .ppIn  (ppBus.snk),
        .scOut (scBus.src)
    );

    // resolve and pick the word, edge 3
    finalAdder uAdd (
        .clk      (clk),
        .arstN    (arstN),
        .scIn     (scBus.snk),
        .outValid (outValid),
        .outTag   (outTag),
        .res      (res)
    );

endmodule

`default_nettype wire

/* sim/mulbt_asserts.sv */
`default_nettype none
`timescale 1ns/10ps

`include "mulbt_cfg.svh"

module mulbt_asserts (
    input wire                      clk,
    input wire                      arstN,
    input wire                      inValid,
    input wire                      outValid,
    input wire [`MULBT_TAG_W-1:0]   outTag,
    input wire [`MULBT_XLEN-1:0]    res
);

    int failCount = 0;     // read by the testbench at the end

    // every accepted operation leaves the pipe three cycles later
    aLatency: assert property (@(posedge clk) disable iff (!arstN)
        inValid |-> ##3 outValid)
        else begin
            failCount++;
            $error("outValid did not follow inValid after three cycles");
        end

    // no result without an accepted operation
    aNoOrphan: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> $past(inValid, 3))
        else begin
            failCount++;
            $error("outValid high without inValid three cycles before");
        end

    aKnown: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> !$isunknown({res, outTag}))
        else begin
            failCount++;
            $error("res or outTag unknown while outValid is high");
        end

    aResetLow: assert property (@(posedge clk) !arstN |-> !outValid)
        else begin
            failCount++;
            $error("outValid high during reset");
        end

endmodule

bind mulbtTop mulbt_asserts uAsserts (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (inValid),
    .outValid (outValid),
    .outTag   (outTag),
    .res      (res)
);

`default_nettype wire

/* sim/mulbt_tb.sv */
`default_nettype none
`timescale 1ns/10ps

`include "mulbt_cfg.svh"

module mulbt_tb;

    import mulbt_pkg::*;

    localparam int DIR_PAIRS = 6;
    localparam int DIR_LEN   = DIR_PAIRS * 4;
    localparam int TBL_LEN   = 72;
    localparam int RST_IDX   = 50;      // mid-run reset right after this entry
    localparam int RST_LEN   = 3;
    localparam int DRAIN     = 5;

    logic                     clk;
    logic                     arstN;
    logic                     inValid;
    logic [`MULBT_TAG_W-1:0]  inTag;
    mulOp_t                   op;
    logic [`MULBT_XLEN-1:0]   op1;
    logic [`MULBT_XLEN-1:0]   op2;
    logic                     outValid;
    logic [`MULBT_TAG_W-1:0]  outTag;
    logic [`MULBT_XLEN-1:0]   res;

    // stimulus table
    mulOp_t                 tblOp  [TBL_LEN];
    logic [`MULBT_XLEN-1:0] tblA   [TBL_LEN];
    logic [`MULBT_XLEN-1:0] tblB   [TBL_LEN];
    int                     tblGap [TBL_LEN];   // idle cycles after the entry

    logic [`MULBT_XLEN-1:0] dirA [DIR_PAIRS] = '{32'h0000_0000, 32'h0000_0001,
        32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF, 32'hFFFF_FFFF};
    logic [`MULBT_XLEN-1:0] dirB [DIR_PAIRS] = '{32'h89AB_CDEF, 32'h0000_0001,
        32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0001};

    // expected results in issue order
    logic [`MULBT_XLEN-1:0]  expQ [$];
    logic [`MULBT_TAG_W-1:0] tagQ [$];
    int                      cycQ [$];

    int errCount   = 0;
    int cycleCnt   = 0;
    int cycleLimit = 0;
    logic [`MULBT_TAG_W-1:0] tagCnt = '0;

    mulbtTop UUT (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inTag    (inTag),
        .op       (op),
        .op1      (op1),
        .op2      (op2),
        .outValid (outValid),
        .outTag   (outTag),
        .res      (res)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    // extend per operation, full 66-bit product, pick the word
    function automatic logic [`MULBT_XLEN-1:0] expectedWord(mulOp_t o,
            logic [`MULBT_XLEN-1:0] a, logic [`MULBT_XLEN-1:0] b);
        logic signed [`MULBT_PP_W-1:0] ax;
        logic signed [`MULBT_PP_W-1:0] bx;
        logic signed [`MULBT_PP_W-1:0] prod;
        logic aSgn;
        logic bSgn;
        aSgn = (o == opMulh) || (o == opMulhsu);
        bSgn = (o == opMulh);
        ax   = {{(`MULBT_PP_W-`MULBT_XLEN){aSgn & a[`MULBT_XLEN-1]}}, a};
        bx   = {{(`MULBT_PP_W-`MULBT_XLEN){bSgn & b[`MULBT_XLEN-1]}}, b};
        prod = ax * bx;
        if (o == opMul)
            return prod[`MULBT_XLEN-1:0];
        else
            return prod[2*`MULBT_XLEN-1:`MULBT_XLEN];
    endfunction

    task automatic buildTable();
        int idx;
        idx = 0;
        for (int p = 0; p < DIR_PAIRS; p++) begin
            for (int o = 0; o < 4; o++) begin     // low and high words back to back
                tblOp[idx]  = mulOp_t'(o);
                tblA[idx]   = dirA[p];
                tblB[idx]   = dirB[p];
                tblGap[idx] = (o == 3) ? (p % 3) : 0;
                idx++;
            end
        end
        for (int i = DIR_LEN; i < TBL_LEN; i++) begin
            tblOp[i]  = mulOp_t'($urandom % 4);
            tblA[i]   = $urandom;
            tblB[i]   = $urandom;
            tblGap[i] = ($urandom % 8 == 0) ? 1 + $urandom % 2 : 0;
        end
    endtask

    task automatic driveOp(mulOp_t o, logic [`MULBT_XLEN-1:0] a,
            logic [`MULBT_XLEN-1:0] b);
        @(posedge clk);
        #1;
        inValid = 1'b1;
        inTag   = tagCnt;
        op      = o;
        op1     = a;
        op2     = b;
        expQ.push_back(expectedWord(o, a, b));
        tagQ.push_back(tagCnt);
        cycQ.push_back(cycleCnt + 3);
        tagCnt  = tagCnt + 1'b1;
    endtask

    task automatic idleCycles(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            inValid = 1'b0;
        end
    endtask

    // in-flight operations are lost, so is what the checker expects
    task automatic pulseReset(int n);
        @(posedge clk);
        #1;
        arstN   = 1'b0;
        inValid = 1'b0;
        expQ.delete();
        tagQ.delete();
        cycQ.delete();
        repeat (n) @(posedge clk);
        #1;
        arstN = 1'b1;
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        logic [`MULBT_XLEN-1:0]  expRes;
        logic [`MULBT_TAG_W-1:0] expTag;
        int                      expCyc;
        if (!arstN) begin
            if (outValid !== 1'b0) begin
                errCount++;
                $display("error at %0t: outValid expected 0 got %b in reset", $time, outValid);
            end
        end else if (outValid === 1'b1) begin
            if (expQ.size() == 0) begin
                errCount++;
                $display("outValid went high at %0t with no operation outstanding", $time);
            end else begin
                expRes = expQ.pop_front();
                expTag = tagQ.pop_front();
                expCyc = cycQ.pop_front();
                if (res !== expRes) begin
                    errCount++;
                    $display("error at %0t: res expected %h got %h", $time, expRes, res);
                end
                if (outTag !== expTag) begin
                    errCount++;
                    $display("error at %0t: outTag expected %h got %h", $time, expTag, outTag);
                end
                if (cycleCnt != expCyc) begin
                    errCount++;
                    $display("error at %0t: outValid cycle expected %0d got %0d",
                             $time, expCyc, cycleCnt);
                end
            end
        end
    end

    initial begin
        wait (cycleLimit > 0);
        wait (cycleCnt >= cycleLimit);
        $display("timeout: run still busy after %0d cycles", cycleCnt);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int total;
        int asrtFails;
        clk     = 1'b0;
        arstN   = 1'b0;
        inValid = 1'b0;
        inTag   = '0;
        op      = opMul;
        op1     = '0;
        op2     = '0;
        void'($urandom(31815));
        buildTable();

        total = 0;
        for (int i = 0; i < TBL_LEN; i++) begin
            total += 1 + tblGap[i];
        end
        cycleLimit = 8 + 4 + total + RST_LEN + 1 + DRAIN + 3 + 20;

        repeat (8) @(posedge clk);
        #1;
        arstN = 1'b1;
        idleCycles(4);      // outValid must stay low here

        for (int i = 0; i < TBL_LEN; i++) begin
            driveOp(tblOp[i], tblA[i], tblB[i]);
            if (i == RST_IDX)
                pulseReset(RST_LEN);
            else
                idleCycles(tblGap[i]);
        end
        idleCycles(DRAIN);
        while (expQ.size() != 0) @(negedge clk);
        idleCycles(2);

        asrtFails = UUT.uAsserts.failCount;
        $display("run done: %0d check errors, %0d assertion failures", errCount, asrtFails);
        if (errCount == 0 && asrtFails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mulbt.f */
+incdir+hw
hw/mulbt_pkg.sv
hw/mulbt_if.sv
hw/boothEncoder.sv
hw/ppGenerator.sv
hw/csaTree.sv
hw/finalAdder.sv
hw/mulbtTop.sv
sim/mulbt_asserts.sv
sim/mulbt_tb.sv
